//--- sim/complete_stimulus.txt
# I unit op a b tag rob dest expected squash (hex), op 0 add 1 sub 2 xor 3 mul
# R rollback_rob rob_tail (hex), G max idle cycles before each issue
G 3
I 0 0 00000005 00000003 01 0 01 00000008 0
I 1 1 00000010 00000004 02 1 02 0000000c 0
I 2 2 0000ff00 00ff00ff 03 2 03 00ffffff 0
I 3 3 00000007 00000006 04 3 04 0000002a 0
I 1 0 ffffffff 00000001 05 4 05 00000000 0
I 0 1 00000000 00000001 06 5 06 ffffffff 0
I 3 3 00010000 00010000 07 6 07 00000000 0
I 2 0 12345678 11111111 08 7 08 23456789 0
I 3 3 0000ffff 0000ffff 09 8 09 fffe0001 0
I 1 2 a5a5a5a5 ffffffff 0a 9 0a 5a5a5a5a 0
# two in flight, killed by the rollback right behind them
G 0
I 3 0 00000001 00000001 0b a 0b 00000002 1
I 2 1 00000009 00000002 0c b 0c 00000007 1
R a b
G 3
I 0 0 00000100 00000200 0d a 0a 00000300 0
I 1 3 00000003 00000005 0e b 0b 0000000f 0
I 2 2 ffffffff 0f0f0f0f 0f c 0c f0f0f0f0 0
I 3 1 00000064 00000065 10 d 0d ffffffff 0
# back-to-back burst on the two lane 0 units
G 0
I 0 0 00000001 00000002 11 e 0e 00000003 0
I 2 3 00000003 00000003 12 f 0f 00000009 0
I 0 1 00000020 00000010 13 0 10 00000010 0
I 2 2 00000011 00000011 14 1 11 00000000 0
I 0 3 00000002 00000080 15 2 12 00000100 0
I 2 0 80000000 80000000 16 3 13 00000000 0
I 3 2 00000001 00000002 17 4 14 00000003 1
I 1 0 00000004 00000004 18 5 15 00000008 1
R 4 5
G 2
I 1 1 00000000 00000005 19 4 16 fffffffb 0
I 2 2 deadbeef ffffffff 1a 5 17 21524110 0
I 0 0 7fffffff 00000001 1b 6 18 80000000 0
I 3 3 00000100 00000100 1c 7 19 00010000 0
# rollback range wraps past index f
G 0
I 3 0 00000002 00000002 1d e 1a 00000004 1
I 2 1 00000002 00000002 1e f 1b 00000000 1
I 1 2 00000002 00000002 1f 0 1c 00000000 1
R e 0

//--- files.f
logic/cdb_pkg.sv
logic/exec_unit.sv
logic/cdb.sv
logic/phys_reg_file.sv
logic/complete_stage.sv
sim/tb_clock.sv
sim/complete_stage_props.sv
sim/complete_stage_tb.sv

//--- Bender.yml
package:
  name: complete_stage

sources:
  # RTL, package first
  - files:
      - logic/cdb_pkg.sv
      - logic/exec_unit.sv
      - logic/cdb.sv
      - logic/phys_reg_file.sv
      - logic/complete_stage.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/complete_stage_props.sv
      - sim/complete_stage_tb.sv

//--- sim/complete_stage_tb.sv
`default_nettype none

module complete_stage_tb import cdb_pkg::*; ();

  localparam int RESET_LIMIT = 50;
  localparam int BUSY_LIMIT  = 100;
  localparam int DRAIN_LIMIT = 500;

  // one expected result per issued tag
  typedef struct packed {
    logic [1:0] unit;
    rob_idx_t   rob;
    arch_reg_t  dest;
    data_t      value;
    logic       squash;
    logic       seen;
  } sb_entry_t;

  logic                      clock;
  logic                      reset;
  logic      [NUM_UNITS-1:0] issue_valid;
  opcode_t                   issue_op;
  data_t                     issue_a;
  data_t                     issue_b;
  tag_t                      issue_tag;
  rob_idx_t                  issue_rob;
  arch_reg_t                 issue_dest;
  logic      [NUM_UNITS-1:0] busy;
  logic                      rollback_en;
  rob_idx_t                  rollback_rob;
  rob_idx_t                  rob_tail;
  logic      [NUM_LANES-1:0] bcast_valid;
  tag_t      [NUM_LANES-1:0] bcast_tag;
  rob_idx_t  [NUM_LANES-1:0] bcast_rob;
  arch_reg_t [NUM_LANES-1:0] bcast_dest;
  data_t     [NUM_LANES-1:0] bcast_value;
  tag_t                      read_tag;
  data_t                     read_value;
  logic                      read_ready;

  sb_entry_t scoreboard [tag_t];
  // flagged tags waiting for the rollback that kills them
  tag_t      squash_pending [$];
  int        live_count;
  int        seen_count;
  int        max_gap;
  integer    seed;

  tb_clock u_clock (
    .clock (clock),
    .reset (reset)
  );

  complete_stage dut (
    .clock        (clock),
    .reset        (reset),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_a      (issue_a),
    .issue_b      (issue_b),
    .issue_tag    (issue_tag),
    .issue_rob    (issue_rob),
    .issue_dest   (issue_dest),
    .busy         (busy),
    .rollback_en  (rollback_en),
    .rollback_rob (rollback_rob),
    .rob_tail     (rob_tail),
    .bcast_valid  (bcast_valid),
    .bcast_tag    (bcast_tag),
    .bcast_rob    (bcast_rob),
    .bcast_dest   (bcast_dest),
    .bcast_value  (bcast_value),
    .read_tag     (read_tag),
    .read_value   (read_value),
    .read_ready   (read_ready)
  );

  task automatic abort_run();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic fail_with(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("** Error: %s expected 0x%h got 0x%h", name, expected, actual);
    abort_run();
  endtask

  // multiply keeps the low word of the full product
  function automatic data_t op_result(input opcode_t op, input data_t a, input data_t b);
    logic [63:0] product;
    data_t       r;
    product = {32'd0, a} * {32'd0, b};
    case (op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_XOR:  r = a ^ b;
      default: r = product[31:0];
    endcase
    return r;
  endfunction

  // circular distances over 16 reorder-buffer entries
  function automatic bit in_rollback(input int idx, input int first, input int tail);
    return ((idx - first + 16) % 16) <= ((tail - first + 16) % 16);
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic wait_unit_free(input int unit);
    int waited;
    waited = 0;
    while (busy[unit] !== 1'b0) begin
      next_cycle();
      waited++;
      if (waited > BUSY_LIMIT) begin
        fail_with($sformatf("unit %0d stayed busy past the timeout", unit));
      end
    end
  endtask

  task automatic apply_issue(input int unit, input opcode_t op, input data_t a,
                             input data_t b, input tag_t tag, input rob_idx_t rob,
                             input arch_reg_t dest, input data_t expected, input logic squash);
    sb_entry_t entry;
    if (unit >= NUM_UNITS) begin
      fail_with($sformatf("stimulus names unit %0d, which does not exist", unit));
    end
    if (scoreboard.exists(tag)) begin
      fail_with($sformatf("stimulus issues tag %h twice", tag));
    end
    if (op_result(op, a, b) !== expected) begin
      fail_with($sformatf("stimulus result for tag %h disagrees with the opcode", tag));
    end
    wait_unit_free(unit);
    entry.unit   = unit[1:0];
    entry.rob    = rob;
    entry.dest   = dest;
    entry.value  = expected;
    entry.squash = squash;
    entry.seen   = 1'b0;
    scoreboard[tag] = entry;
    if (squash) begin
      squash_pending.push_back(tag);
    end else begin
      live_count++;
    end
    issue_valid       = '0;
    issue_valid[unit] = 1'b1;
    issue_op          = op;
    issue_a           = a;
    issue_b           = b;
    issue_tag         = tag;
    issue_rob         = rob;
    issue_dest        = dest;
    next_cycle();
    issue_valid = '0;
  endtask

  task automatic apply_rollback(input rob_idx_t first, input rob_idx_t tail);
    foreach (squash_pending[i]) begin
      if (!in_rollback(scoreboard[squash_pending[i]].rob, first, tail)) begin
        fail_with($sformatf("flagged tag %h lies outside the rollback range", squash_pending[i]));
      end
    end
    squash_pending.delete();
    rollback_en  = 1'b1;
    rollback_rob = first;
    rob_tail     = tail;
    next_cycle();
    rollback_en = 1'b0;
  endtask

  task automatic check_bcast(input int lane, input tag_t tag, input rob_idx_t rob,
                             input arch_reg_t dest, input data_t value);
    sb_entry_t entry;
    if (!scoreboard.exists(tag)) begin
      fail_with($sformatf("lane %0d broadcast tag %h, which was never issued", lane, tag));
    end
    entry = scoreboard[tag];
    if (entry.squash) begin
      fail_with($sformatf("lane %0d broadcast squashed tag %h", lane, tag));
    end
    if (entry.seen) begin
      fail_with($sformatf("tag %h was broadcast a second time", tag));
    end
    if ((int'(entry.unit) % NUM_LANES) != lane) begin
      fail_with($sformatf("tag %h from unit %0d came out on lane %0d", tag, entry.unit, lane));
    end
    if (rob !== entry.rob) begin
      report_mismatch($sformatf("bcast_rob[%0d]", lane), entry.rob, rob);
    end
    if (dest !== entry.dest) begin
      report_mismatch($sformatf("bcast_dest[%0d]", lane), entry.dest, dest);
    end
    if (value !== entry.value) begin
      report_mismatch($sformatf("bcast_value[%0d]", lane), entry.value, value);
    end
    entry.seen = 1'b1;
    scoreboard[tag] = entry;
    seen_count++;
  endtask

  task automatic check_read(input tag_t tag, input data_t expected, input logic ready);
    if (read_ready !== ready) begin
      report_mismatch($sformatf("read_ready for tag %h", tag), ready, read_ready);
    end
    if (ready && (read_value !== expected)) begin
      report_mismatch($sformatf("read_value for tag %h", tag), expected, read_value);
    end
  endtask

  // lanes sampled on the edge that also writes the register file
  always @(posedge clock) begin
    if (reset === 1'b0) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        if (bcast_valid[k]) begin
          check_bcast(k, bcast_tag[k], bcast_rob[k], bcast_dest[k], bcast_value[k]);
        end
      end
    end
  end

  // a bus property failure stops the run at the next edge
  always @(posedge clock) begin
    if (dut.props.fail_count != 0) begin
      fail_with("a bus property assertion failed");
    end
  end

  initial begin
    int          fd;
    int          fields;
    int          gap;
    int          waited;
    byte         kind;
    string       line;
    logic [31:0] f_unit;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_tag;
    logic [31:0] f_rob;
    logic [31:0] f_dest;
    logic [31:0] f_exp;
    logic [31:0] f_sq;

    issue_valid  = '0;
    issue_op     = '0;
    issue_a      = '0;
    issue_b      = '0;
    issue_tag    = '0;
    issue_rob    = '0;
    issue_dest   = '0;
    rollback_en  = 1'b0;
    rollback_rob = '0;
    rob_tail     = '0;
    read_tag     = '0;
    live_count   = 0;
    seen_count   = 0;
    max_gap      = 0;
    seed         = 32'hd3cd;

    waited = 0;
    @(posedge clock);
    while (reset !== 1'b0) begin
      waited++;
      if (waited > RESET_LIMIT) begin
        fail_with("reset was never released");
      end
      @(posedge clock);
    end
    #1;

    fd = $fopen("sim/complete_stimulus.txt", "r");
    if (fd == 0) begin
      fail_with("cannot open the stimulus file");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0) begin
        continue;
      end
      kind = line[0];
      case (kind)
        "I": begin
          fields = $sscanf(line, "I %h %h %h %h %h %h %h %h %h", f_unit, f_op, f_a,
                           f_b, f_tag, f_rob, f_dest, f_exp, f_sq);
          if (fields != 9) begin
            fail_with($sformatf("malformed issue line: %s", line));
          end
          gap = $unsigned($random(seed)) % (max_gap + 1);
          repeat (gap) next_cycle();
          apply_issue(f_unit, f_op[1:0], f_a, f_b, f_tag[4:0], f_rob[3:0], f_dest[4:0],
                      f_exp, f_sq[0]);
        end
        "R": begin
          fields = $sscanf(line, "R %h %h", f_rob, f_exp);
          if (fields != 2) begin
            fail_with($sformatf("malformed rollback line: %s", line));
          end
          apply_rollback(f_rob[3:0], f_exp[3:0]);
        end
        "G": begin
          fields = $sscanf(line, "G %d", max_gap);
          if (fields != 1) begin
            fail_with($sformatf("malformed gap line: %s", line));
          end
        end
        // comments and blank lines
        "#", 8'h0a, 8'h0d: ;
        default: fail_with($sformatf("unknown stimulus line: %s", line));
      endcase
    end
    $fclose(fd);
    if (squash_pending.size() != 0) begin
      fail_with("flagged instructions were never rolled back");
    end

    // drain and leave time for any stray broadcast
    waited = 0;
    while ((seen_count < live_count) || (busy !== '0)) begin
      next_cycle();
      waited++;
      if (waited > DRAIN_LIMIT) begin
        fail_with("results did not drain, a live tag was never broadcast");
      end
    end
    repeat (10) next_cycle();

    foreach (scoreboard[t]) begin
      read_tag = t;
      @(posedge clock);
      check_read(t, scoreboard[t].value, !scoreboard[t].squash);
      #1;
    end

    if (dut.props.fail_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("bus property checks reported %0d failures", dut.props.fail_count);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- sim/complete_stage_props.sv
`default_nettype none

module complete_stage_props import cdb_pkg::*; (
  input wire logic                 clock,
  input wire logic                 reset,
  input wire logic [NUM_LANES-1:0] bcast_valid,
  input wire tag_t [NUM_LANES-1:0] bcast_tag
);

  // assertion failures so far
  int unsigned fail_count;
  logic        reset_seen;

  initial begin
    fail_count = 0;
    reset_seen = 1'b0;
  end

  // slots only hold known state after the first reset edge
  always @(posedge clock) begin
    if (reset) begin
      reset_seen <= 1'b1;
    end
  end

  a_quiet_in_reset: assert property (@(posedge clock)
    (reset && reset_seen) |-> (bcast_valid == '0))
    else begin
      fail_count++;
      $error("bus lane valid while reset is held");
    end

  // one tag never goes out on both lanes at once
  a_distinct_tags: assert property (@(posedge clock) disable iff (reset)
    !(bcast_valid[0] && bcast_valid[1] && (bcast_tag[0] == bcast_tag[1])))
    else begin
      fail_count++;
      $error("both lanes carry tag %h", bcast_tag[0]);
    end

  // nothing can have reached a slot yet
  a_quiet_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> (bcast_valid == '0))
    else begin
      fail_count++;
      $error("bus lane valid in the first cycle after reset");
    end

  a_valid_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(bcast_valid))
    else begin
      fail_count++;
      $error("bus lane valid is unknown");
    end

endmodule

bind complete_stage complete_stage_props props (
  .clock       (clock),
  .reset       (reset),
  .bcast_valid (bcast_valid),
  .bcast_tag   (bcast_tag)
);

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clock,
  output logic reset
);

  // period of 4 time units
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // reset held for 10 rising edges, released just after the last one
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    #1 reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/complete_stage.sv
`default_nettype none

module complete_stage import cdb_pkg::*; (
  input  wire logic                           clock,
  input  wire logic                           reset,
  input  wire logic      [NUM_UNITS-1:0]      issue_valid,
  input  wire opcode_t                        issue_op,
  input  wire data_t                          issue_a,
  input  wire data_t                          issue_b,
  input  wire tag_t                           issue_tag,
  input  wire rob_idx_t                       issue_rob,
  input  wire arch_reg_t                      issue_dest,
  output logic           [NUM_UNITS-1:0]      busy,
  input  wire logic                           rollback_en,
  input  wire rob_idx_t                       rollback_rob,
  input  wire rob_idx_t                       rob_tail,
  output logic           [NUM_LANES-1:0]      bcast_valid,
  output tag_t           [NUM_LANES-1:0]      bcast_tag,
  output rob_idx_t       [NUM_LANES-1:0]      bcast_rob,
  output arch_reg_t      [NUM_LANES-1:0]      bcast_dest,
  output data_t          [NUM_LANES-1:0]      bcast_value,
  input  wire tag_t                           read_tag,
  output data_t                               read_value,
  output logic                                read_ready
);

  // unit to buffer
  logic      [NUM_UNITS-1:0] unit_done;
  data_t     [NUM_UNITS-1:0] unit_result;
  tag_t      [NUM_UNITS-1:0] unit_tag;
  rob_idx_t  [NUM_UNITS-1:0] unit_rob;
  arch_reg_t [NUM_UNITS-1:0] unit_dest;
  logic      [NUM_UNITS-1:0] slot_free;

  // operand buses are shared, issue_valid picks the unit
  for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
    exec_unit #(
      .LATENCY (UNIT_LATENCY[i])
    ) u_exec (
      .clock        (clock),
      .reset        (reset),
      .issue_valid  (issue_valid[i]),
      .issue_op     (issue_op),
      .issue_a      (issue_a),
      .issue_b      (issue_b),
      .issue_tag    (issue_tag),
      .issue_rob    (issue_rob),
      .issue_dest   (issue_dest),
      .rollback_en  (rollback_en),
      .rollback_rob (rollback_rob),
      .rob_tail     (rob_tail),
      .slot_free    (slot_free[i]),
      .busy         (busy[i]),
      .done         (unit_done[i]),
      .result       (unit_result[i]),
      .tag          (unit_tag[i]),
      .rob          (unit_rob[i]),
      .dest         (unit_dest[i])
    );
  end

  cdb u_cdb (
    .clock        (clock),
    .reset        (reset),
    .unit_done    (unit_done),
    .unit_result  (unit_result),
    .unit_tag     (unit_tag),
    .unit_rob     (unit_rob),
    .unit_dest    (unit_dest),
    .rollback_en  (rollback_en),
    .rollback_rob (rollback_rob),
    .rob_tail     (rob_tail),
    .slot_free    (slot_free),
    .bcast_valid  (bcast_valid),
    .bcast_tag    (bcast_tag),
    .bcast_rob    (bcast_rob),
    .bcast_dest   (bcast_dest),
    .bcast_value  (bcast_value)
  );

  // any issue allocates its destination tag
  phys_reg_file u_prf (
    .clock        (clock),
    .reset        (reset),
    .alloc_valid  (|issue_valid),
    .alloc_tag    (issue_tag),
    .bcast_valid  (bcast_valid),
    .bcast_tag    (bcast_tag),
    .bcast_value  (bcast_value),
    .read_tag     (read_tag),
    .read_value   (read_value),
    .read_ready   (read_ready)
  );

endmodule

`default_nettype wire

//--- logic/phys_reg_file.sv
`default_nettype none

module phys_reg_file import cdb_pkg::*; (
  input  wire logic                  clock,
  input  wire logic                  reset,
  input  wire logic                  alloc_valid,
  input  wire tag_t                  alloc_tag,
  input  wire logic  [NUM_LANES-1:0] bcast_valid,
  input  wire tag_t  [NUM_LANES-1:0] bcast_tag,
  input  wire data_t [NUM_LANES-1:0] bcast_value,
  input  wire tag_t                  read_tag,
  output data_t                      read_value,
  output logic                       read_ready
);

  data_t                regs [NUM_PREGS];
  logic [NUM_PREGS-1:0] ready;

  // ready bits
  always_ff @(posedge clock) begin
    if (reset) begin
      ready <= '0;
    end else begin
      // new destination waits for its result
      if (alloc_valid) begin
        ready[alloc_tag] <= 1'b0;
      end
      // lane writes come last so they win on a tag clash
      for (int k = 0; k < NUM_LANES; k++) begin
        if (bcast_valid[k]) begin
          ready[bcast_tag[k]] <= 1'b1;
        end
      end
    end
  end

  // values
  always_ff @(posedge clock) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (bcast_valid[k]) begin
        regs[bcast_tag[k]] <= bcast_value[k];
      end
    end
  end

  assign read_value = regs[read_tag];
  assign read_ready = ready[read_tag];

endmodule

`default_nettype wire

//--- logic/cdb.sv
`default_nettype none

module cdb import cdb_pkg::*; (
  input  wire logic                            clock,
  input  wire logic                            reset,
  input  wire logic      [NUM_UNITS-1:0]       unit_done,
  input  wire data_t     [NUM_UNITS-1:0]       unit_result,
  input  wire tag_t      [NUM_UNITS-1:0]       unit_tag,
  input  wire rob_idx_t  [NUM_UNITS-1:0]       unit_rob,
  input  wire arch_reg_t [NUM_UNITS-1:0]       unit_dest,
  input  wire logic                            rollback_en,
  input  wire rob_idx_t                        rollback_rob,
  input  wire rob_idx_t                        rob_tail,
  output logic           [NUM_UNITS-1:0]       slot_free,
  output logic           [NUM_LANES-1:0]       bcast_valid,
  output tag_t           [NUM_LANES-1:0]       bcast_tag,
  output rob_idx_t       [NUM_LANES-1:0]       bcast_rob,
  output arch_reg_t      [NUM_LANES-1:0]       bcast_dest,
  output data_t          [NUM_LANES-1:0]       bcast_value
);

  // slot state, one per unit
  logic      [NUM_UNITS-1:0] slot_taken;
  tag_t      [NUM_UNITS-1:0] slot_tag;
  rob_idx_t  [NUM_UNITS-1:0] slot_rob;
  arch_reg_t [NUM_UNITS-1:0] slot_dest;
  data_t     [NUM_UNITS-1:0] slot_value;

  logic      [NUM_UNITS-1:0] slot_squash;
  logic      [NUM_UNITS-1:0] unit_squash;
  logic      [NUM_UNITS-1:0] sending;
  logic      [NUM_UNITS-1:0] capture;
  unit_idx_t [NUM_LANES-1:0] lane_sel;

  // squash checks on held slots and on results arriving this edge
  always_comb begin
    for (int i = 0; i < NUM_UNITS; i++) begin
      slot_squash[i] = rollback_en && slot_taken[i] &&
                       in_squash_range(slot_rob[i], rollback_rob, rob_tail);
      // a unit squashed on this edge must not slip into its slot
      unit_squash[i] = rollback_en &&
                       in_squash_range(unit_rob[i], rollback_rob, rob_tail);
    end
  end

  // lane k scans units k, k+NUM_LANES, ... lowest index wins
  always_comb begin
    sending = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      bcast_valid[k] = 1'b0;
      lane_sel[k]    = unit_idx_t'(k);
      for (int j = k; j < NUM_UNITS; j += NUM_LANES) begin
        if (!bcast_valid[k] && slot_taken[j] && !slot_squash[j]) begin
          bcast_valid[k] = 1'b1;
          lane_sel[k]    = unit_idx_t'(j);
          sending[j]     = 1'b1;
        end
      end
    end
  end

  // payload follows the selected slot, bcast_valid qualifies it
  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      bcast_tag[k]   = slot_tag[lane_sel[k]];
      bcast_rob[k]   = slot_rob[lane_sel[k]];
      bcast_dest[k]  = slot_dest[lane_sel[k]];
      bcast_value[k] = slot_value[lane_sel[k]];
    end
  end

  // free when empty, squashed or draining this cycle
  // lets one slot take a new result every cycle
  always_comb begin
    for (int i = 0; i < NUM_UNITS; i++) begin
      slot_free[i] = !slot_taken[i] || slot_squash[i] || sending[i];
      capture[i]   = slot_free[i] && unit_done[i] && !unit_squash[i];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      slot_taken <= '0;
    end else begin
      for (int i = 0; i < NUM_UNITS; i++) begin
        if (capture[i]) begin
          slot_taken[i] <= 1'b1;
        end else if (slot_free[i]) begin
          slot_taken[i] <= 1'b0;
        end
      end
    end
  end

  // slot payload
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_UNITS; i++) begin
      if (capture[i]) begin
        slot_tag[i]   <= unit_tag[i];
        slot_rob[i]   <= unit_rob[i];
        slot_dest[i]  <= unit_dest[i];
        slot_value[i] <= unit_result[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`default_nettype none

module exec_unit import cdb_pkg::*; #(
  parameter int LATENCY = 1
) (
  input  wire logic      clock,
  input  wire logic      reset,
  input  wire logic      issue_valid,
  input  wire opcode_t   issue_op,
  input  wire data_t     issue_a,
  input  wire data_t     issue_b,
  input  wire tag_t      issue_tag,
  input  wire rob_idx_t  issue_rob,
  input  wire arch_reg_t issue_dest,
  input  wire logic      rollback_en,
  input  wire rob_idx_t  rollback_rob,
  input  wire rob_idx_t  rob_tail,
  input  wire logic      slot_free,
  output logic           busy,
  output logic           done,
  output data_t          result,
  output tag_t           tag,
  output rob_idx_t       rob,
  output arch_reg_t      dest
);

  // counter wide enough for LATENCY-1, at least one bit
  localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_compute,
    st_hold
  } state_t;

  state_t           state;
  logic [CNT_W-1:0] count;
  opcode_t          op_q;
  data_t            a_q;
  data_t            b_q;
  data_t            alu_out;
  logic             squash;

  // rollback only matters while an instruction is held
  assign squash = rollback_en && (state != st_idle) &&
                  in_squash_range(rob, rollback_rob, rob_tail);

  assign busy = (state != st_idle);
  assign done = (state == st_hold);

  always_comb begin
    case (op_q)
      OP_ADD:  alu_out = a_q + b_q;
      OP_SUB:  alu_out = a_q - b_q;
      OP_XOR:  alu_out = a_q ^ b_q;
      default: alu_out = a_q * b_q;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (issue_valid) begin
            state <= st_compute;
            count <= CNT_W'(LATENCY - 1);
          end
        end
        st_compute: begin
          // last count edge moves to hold with the result
          if (count == '0) begin
            state <= st_hold;
          end else begin
            count <= count - 1'b1;
          end
        end
        st_hold: begin
          // result leaves on the edge the slot accepts it
          if (slot_free) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
      // squash overrides any progress
      if (squash) begin
        state <= st_idle;
      end
    end
  end

  // operand and result registers
  always_ff @(posedge clock) begin
    if (state == st_idle && issue_valid) begin
      op_q <= issue_op;
      a_q  <= issue_a;
      b_q  <= issue_b;
      tag  <= issue_tag;
      rob  <= issue_rob;
      dest <= issue_dest;
    end
    if (state == st_compute && count == '0) begin
      result <= alu_out;
    end
  end

endmodule

`default_nettype wire

//--- logic/cdb_pkg.sv
`default_nettype none

package cdb_pkg;

  // datapath and tag widths
  typedef logic [31:0] data_t;
  typedef logic [4:0]  tag_t;
  typedef logic [3:0]  rob_idx_t;
  typedef logic [4:0]  arch_reg_t;
  typedef logic [1:0]  opcode_t;

  // unit operations
  localparam opcode_t OP_ADD = 2'd0;
  localparam opcode_t OP_SUB = 2'd1;
  localparam opcode_t OP_XOR = 2'd2;
  // low half of the product only
  localparam opcode_t OP_MUL = 2'd3;

  localparam int NUM_UNITS = 4;
  localparam int NUM_LANES = 2;
  localparam int NUM_PREGS = 32;

  // selects one unit slot on a lane
  typedef logic [$clog2(NUM_UNITS)-1:0] unit_idx_t;

  // cycles from issue to done, per unit
  localparam int UNIT_LATENCY [NUM_UNITS] = '{1, 1, 2, 3};

  // true when idx lies in the circular range [rollback_rob, rob_tail]
  // distances wrap modulo 16 through the rob_idx_t width
  function automatic logic in_squash_range(
    input rob_idx_t idx,
    input rob_idx_t rollback_rob,
    input rob_idx_t rob_tail
  );
    rob_idx_t entry_dist;
    rob_idx_t tail_dist;
    entry_dist = idx - rollback_rob;
    tail_dist  = rob_tail - rollback_rob;
    return entry_dist <= tail_dist;
  endfunction

endpackage

`default_nettype wire
